/* aes_consts.svh */
/*
  Sizing constants for the AES-128 encryption engine
  Included by the package and by any module that sizes counters or pipeline stages
*/
`ifndef AES_CONSTS_SVH
`define AES_CONSTS_SVH

// Cipher rounds after the initial AddRoundKey
`define AES_NUM_ROUNDS 10

// Result queue entries, at least pipeline latency plus one for full throughput
`define AES_QUEUE_DEPTH 16

// Output credit counter width
`define AES_CREDIT_WIDTH 5

// Queue occupancy and reservation counters, must hold AES_QUEUE_DEPTH
`define AES_COUNT_WIDTH 5

`endif

/* aesPkg.sv */
/*
  Shared types and GF(2^8) arithmetic for the AES-128 encryption engine
  Imported by the key schedule, the cipher rounds and the top level
*/
`default_nettype none

`include "aes_consts.svh"

package aesPkg;

  // Bytes in column-major order, byte 0 is the most significant
  typedef logic [0:15][7:0] stateT;
  typedef logic [0:15][7:0] roundKeyT;
  typedef roundKeyT [0:`AES_NUM_ROUNDS] roundKeysT;

  typedef struct packed {
    stateT      block;
    logic [7:0] tag;
  } cipherInT;

  typedef struct packed {
    stateT      cipherText;
    logic [7:0] tag;
  } cipherOutT;

  typedef enum logic [1:0] {
    IDLE,
    EXPAND,
    READY
  } keySchedStateT;

  // Multiply by x modulo the AES polynomial
  function automatic logic [7:0] xtime(input logic [7:0] a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] p;
    acc = 8'h00;
    p = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        acc = acc ^ p;
      p = xtime(p);
    end
    return acc;
  endfunction

  // Inverse as a^254 then the affine transform, zero maps to 0x63
  function automatic logic [7:0] sBox(input logic [7:0] a);
    logic [7:0] inv;
    logic [7:0] pw;
    inv = 8'h01;
    pw = a;
    for (int i = 1; i < 8; i++)
    begin
      pw = gfMul(pw, pw);
      inv = gfMul(inv, pw);
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
           {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
  endfunction

endpackage

`default_nettype wire

/* aesKeySchedule.sv */
/*
  Key configuration block beside the cipher pipeline
  A keyWrite pulse loads the key, then one round key per cycle is expanded and stored
*/
`timescale 1ns/1ps
`default_nettype none

`include "aes_consts.svh"

module aesKeySchedule
  import aesPkg::*;
(
  input  logic      clock,
  input  logic      rst,
  input  logic      keyWrite,
  input  roundKeyT  keyIn,
  output roundKeysT roundKeys,
  output logic      keyReady
);

  localparam int idxWidth = $clog2(`AES_NUM_ROUNDS + 1);

  keySchedStateT         state;
  logic [idxWidth-1:0]   roundIdx;
  roundKeyT              curKey;
  roundKeyT              nextKey;
  logic [7:0]            rcon;
  logic [0:3][7:0]       tempWord;

  // RotWord, SubWord and Rcon on the last word, then the running XOR chain
  always_comb
  begin
    tempWord[0] = sBox(curKey[13]) ^ rcon;
    tempWord[1] = sBox(curKey[14]);
    tempWord[2] = sBox(curKey[15]);
    tempWord[3] = sBox(curKey[12]);
    for (int b = 0; b < 4; b++)
    begin
      nextKey[b]      = curKey[b] ^ tempWord[b];
      nextKey[4 + b]  = curKey[4 + b] ^ nextKey[b];
      nextKey[8 + b]  = curKey[8 + b] ^ nextKey[4 + b];
      nextKey[12 + b] = curKey[12 + b] ^ nextKey[8 + b];
    end
  end

  // Eleven EXPAND cycles store keys 0 to 10, a new write restarts expansion
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      state    <= IDLE;
      roundIdx <= '0;
    end
    else if (keyWrite)
    begin
      state    <= EXPAND;
      roundIdx <= '0;
    end
    else if (state == EXPAND)
    begin
      if (roundIdx == idxWidth'(`AES_NUM_ROUNDS))
        state <= READY;
      else
        roundIdx <= roundIdx + 1'b1;
    end
  end

  // Working key and round constant advance together with the store
  always_ff @(posedge clock)
  begin
    if (keyWrite)
    begin
      curKey <= keyIn;
      rcon   <= 8'h01;
    end
    else if (state == EXPAND)
    begin
      roundKeys[roundIdx] <= curKey;
      curKey              <= nextKey;
      rcon                <= xtime(rcon);
    end
  end

  assign keyReady = (state == READY);

endmodule

`default_nettype wire

/* aesRound.sv */
/*
  One registered AES cipher round with valid and tag carried alongside
  Set isFinal for the last round, which skips MixColumns
*/
`timescale 1ns/1ps
`default_nettype none

module aesRound
  import aesPkg::*;
#(
  parameter bit isFinal = 1'b0
)
(
  input  logic     clock,
  input  logic     rst,
  input  logic     inValid,
  input  cipherInT inBlock,
  input  roundKeyT roundKey,
  output logic     outValid,
  output cipherInT outBlock
);

  stateT subState;
  stateT shiftState;
  stateT mixState;
  stateT roundState;

  always_comb
  begin
    for (int i = 0; i < 16; i++)
      subState[i] = sBox(inBlock.block[i]);

    // Row r rotates left by r columns
    for (int c = 0; c < 4; c++)
      for (int r = 0; r < 4; r++)
        shiftState[4 * c + r] = subState[4 * ((c + r) % 4) + r];

    for (int c = 0; c < 4; c++)
      for (int r = 0; r < 4; r++)
        mixState[4 * c + r] = gfMul(shiftState[4 * c + r], 8'h02) ^
                              gfMul(shiftState[4 * c + (r + 1) % 4], 8'h03) ^
                              shiftState[4 * c + (r + 2) % 4] ^
                              shiftState[4 * c + (r + 3) % 4];

    roundState = (isFinal ? shiftState : mixState) ^ roundKey;
  end

  always_ff @(posedge clock)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= inValid;
  end

  always_ff @(posedge clock)
  begin
    outBlock.block <= roundState;
    outBlock.tag   <= inBlock.tag;
  end

endmodule

`default_nettype wire

/* aesCipherPipe.sv */
/*
  AES-128 cipher pipeline, an initial AddRoundKey stage and ten registered rounds
  Accepts one block per cycle with a fixed latency of eleven cycles
*/
`timescale 1ns/1ps
`default_nettype none

`include "aes_consts.svh"

module aesCipherPipe
  import aesPkg::*;
(
  input  logic      clock,
  input  logic      rst,
  input  logic      inValid,
  input  cipherInT  inBlock,
  input  roundKeysT roundKeys,
  output logic      resValid,
  output cipherOutT resData
);

  logic     firstValid;
  cipherInT firstBlock;

  // Stage outputs, index 0 is the initial AddRoundKey
  logic     stageValid [0:`AES_NUM_ROUNDS];
  cipherInT stageBlock [0:`AES_NUM_ROUNDS];

  always_ff @(posedge clock)
  begin
    if (rst)
      firstValid <= 1'b0;
    else
      firstValid <= inValid;
  end

  always_ff @(posedge clock)
  begin
    firstBlock.block <= inBlock.block ^ roundKeys[0];
    firstBlock.tag   <= inBlock.tag;
  end

  assign stageValid[0] = firstValid;
  assign stageBlock[0] = firstBlock;

  genvar i;
  generate
    for (i = 1; i <= `AES_NUM_ROUNDS; i++)
    begin : roundGen
      aesRound #(
        .isFinal (i == `AES_NUM_ROUNDS)
      ) roundInst (
        .clock    (clock),
        .rst      (rst),
        .inValid  (stageValid[i - 1]),
        .inBlock  (stageBlock[i - 1]),
        .roundKey (roundKeys[i]),
        .outValid (stageValid[i]),
        .outBlock (stageBlock[i])
      );
    end
  endgenerate

  assign resValid = stageValid[`AES_NUM_ROUNDS];
  assign resData  = '{cipherText: stageBlock[`AES_NUM_ROUNDS].block,
                      tag: stageBlock[`AES_NUM_ROUNDS].tag};

endmodule

`default_nettype wire

/* aesOutQueue.sv */
/*
  Result FIFO with a slot reserved for every accepted block until it leaves
  Results are released under credit flow control, one credit per result
*/
`timescale 1ns/1ps
`default_nettype none

`include "aes_consts.svh"

module aesOutQueue
  import aesPkg::*;
(
  input  logic      clock,
  input  logic      rst,
  input  logic      inValid,
  input  logic      keyReady,
  input  logic      resValid,
  input  cipherOutT resData,
  input  logic      outCredit,
  output logic      inReady,
  output logic      accept,
  output logic      outValid,
  output cipherOutT outData
);

  // Pointers wrap naturally, depth is a power of two
  localparam int ptrWidth = $clog2(`AES_QUEUE_DEPTH);
  localparam logic [`AES_COUNT_WIDTH-1:0] depthLimit = `AES_QUEUE_DEPTH;

  cipherOutT                    mem [0:`AES_QUEUE_DEPTH-1];
  logic [ptrWidth-1:0]          wrPtr;
  logic [ptrWidth-1:0]          rdPtr;
  logic [`AES_COUNT_WIDTH-1:0]  storedCount;
  logic [`AES_COUNT_WIDTH-1:0]  reservedCount;
  logic [`AES_CREDIT_WIDTH-1:0] creditCount;
  logic                         pop;

  // Reservations cover stored entries plus blocks still in the pipeline
  assign inReady  = keyReady && (reservedCount < depthLimit);
  assign accept   = inValid && inReady;
  assign pop      = (storedCount != '0) && (creditCount != '0);
  assign outValid = pop;
  assign outData  = mem[rdPtr];

  always_ff @(posedge clock)
  begin
    if (resValid)
      mem[wrPtr] <= resData;
  end

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      wrPtr         <= '0;
      rdPtr         <= '0;
      storedCount   <= '0;
      reservedCount <= '0;
      creditCount   <= '0;
    end
    else
    begin
      if (resValid)
        wrPtr <= wrPtr + 1'b1;
      if (pop)
        rdPtr <= rdPtr + 1'b1;

      if (resValid && !pop)
        storedCount <= storedCount + 1'b1;
      else if (!resValid && pop)
        storedCount <= storedCount - 1'b1;

      if (accept && !pop)
        reservedCount <= reservedCount + 1'b1;
      else if (!accept && pop)
        reservedCount <= reservedCount - 1'b1;

      if (outCredit && !pop)
        creditCount <= creditCount + 1'b1;
      else if (!outCredit && pop)
        creditCount <= creditCount - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* aesEncoderTop.sv */
/*
  Top level of the pipelined AES-128 encryption engine
  Load a key, wait for keyReady, then stream tagged blocks and return output credits
*/
`timescale 1ns/1ps
`default_nettype none

module aesEncoderTop
  import aesPkg::*;
(
  input  logic      clock,
  input  logic      rst,
  input  logic      keyWrite,
  input  roundKeyT  keyIn,
  output logic      keyReady,
  input  logic      inValid,
  input  cipherInT  inData,
  output logic      inReady,
  output logic      outValid,
  output cipherOutT outData,
  input  logic      outCredit
);

  roundKeysT roundKeys;
  logic      accept;
  logic      resValid;
  cipherOutT resData;

  aesKeySchedule keySched0 (
    .clock     (clock),
    .rst       (rst),
    .keyWrite  (keyWrite),
    .keyIn     (keyIn),
    .roundKeys (roundKeys),
    .keyReady  (keyReady)
  );

  // Only admitted blocks enter the pipeline
  aesCipherPipe pipe0 (
    .clock     (clock),
    .rst       (rst),
    .inValid   (accept),
    .inBlock   (inData),
    .roundKeys (roundKeys),
    .resValid  (resValid),
    .resData   (resData)
  );

  aesOutQueue queue0 (
    .clock     (clock),
    .rst       (rst),
    .inValid   (inValid),
    .keyReady  (keyReady),
    .resValid  (resValid),
    .resData   (resData),
    .outCredit (outCredit),
    .inReady   (inReady),
    .accept    (accept),
    .outValid  (outValid),
    .outData   (outData)
  );

endmodule

`default_nettype wire

/* aesRefModel.svh */
/*
  Behavioural AES-128 model and in-order result scoreboard for the encoder testbench
  Included inside the testbench module, which provides errorCount
*/
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

logic [7:0] sboxTable [0:255];
bit         sboxBuilt = 1'b0;
cipherOutT  expQ [$];
cipherOutT  lastOut;

function automatic logic [7:0] mulTwo(input logic [7:0] a);
  logic [7:0] shifted;
  shifted = a << 1;
  if (a[7])
    shifted = shifted ^ 8'h1b;
  return shifted;
endfunction

// Walk the generator 3 and its inverse together to fill the table
function automatic void buildSbox();
  logic [7:0] p;
  logic [7:0] q;
  logic [7:0] x;
  p = 8'h01;
  q = 8'h01;
  sboxTable[0] = 8'h63;
  for (int n = 0; n < 255; n++)
  begin
    p = p ^ mulTwo(p);
    q = q ^ (q << 1);
    q = q ^ (q << 2);
    q = q ^ (q << 4);
    if (q[7])
      q = q ^ 8'h09;
    x = q ^ {q[6:0], q[7]} ^ {q[5:0], q[7:6]} ^ {q[4:0], q[7:5]} ^ {q[3:0], q[7:4]};
    sboxTable[p] = x ^ 8'h63;
  end
  sboxBuilt = 1'b1;
endfunction

function automatic logic [127:0] encrypt(input logic [127:0] key, input logic [127:0] pt);
  logic [31:0]  w [0:43];
  logic [7:0]   s [0:15];
  logic [7:0]   t [0:15];
  logic [31:0]  temp;
  logic [7:0]   rc;
  logic [7:0]   a0, a1, a2, a3;
  logic [127:0] res;
  if (!sboxBuilt)
    buildSbox();
  rc = 8'h01;
  for (int i = 0; i < 4; i++)
    w[i] = key[127 - 32 * i -: 32];
  for (int i = 4; i < 44; i++)
  begin
    temp = w[i - 1];
    if (i % 4 == 0)
    begin
      temp = {temp[23:0], temp[31:24]};
      temp = {sboxTable[temp[31:24]], sboxTable[temp[23:16]],
              sboxTable[temp[15:8]], sboxTable[temp[7:0]]};
      temp[31:24] = temp[31:24] ^ rc;
      rc = mulTwo(rc);
    end
    w[i] = w[i - 4] ^ temp;
  end
  for (int i = 0; i < 16; i++)
    s[i] = pt[127 - 8 * i -: 8] ^ w[i / 4][31 - 8 * (i % 4) -: 8];
  for (int r = 1; r <= 10; r++)
  begin
    for (int i = 0; i < 16; i++)
      t[i] = sboxTable[s[i]];
    for (int c = 0; c < 4; c++)
      for (int row = 0; row < 4; row++)
        s[4 * c + row] = t[4 * ((c + row) % 4) + row];
    if (r < 10)
    begin
      for (int c = 0; c < 4; c++)
      begin
        a0 = s[4 * c];
        a1 = s[4 * c + 1];
        a2 = s[4 * c + 2];
        a3 = s[4 * c + 3];
        s[4 * c]     = mulTwo(a0) ^ mulTwo(a1) ^ a1 ^ a2 ^ a3;
        s[4 * c + 1] = a0 ^ mulTwo(a1) ^ mulTwo(a2) ^ a2 ^ a3;
        s[4 * c + 2] = a0 ^ a1 ^ mulTwo(a2) ^ mulTwo(a3) ^ a3;
        s[4 * c + 3] = mulTwo(a0) ^ a0 ^ a1 ^ a2 ^ mulTwo(a3);
      end
    end
    for (int i = 0; i < 16; i++)
      s[i] = s[i] ^ w[4 * r + i / 4][31 - 8 * (i % 4) -: 8];
  end
  for (int i = 0; i < 16; i++)
    res[127 - 8 * i -: 8] = s[i];
  return res;
endfunction

task automatic pushExpected(input cipherInT blk, input logic [127:0] key);
  cipherOutT e;
  e.cipherText = encrypt(key, blk.block);
  e.tag = blk.tag;
  expQ.push_back(e);
endtask

// Results leave in acceptance order, so the oldest entry must match
task automatic checkOutput(input cipherOutT got);
  cipherOutT e;
  lastOut = got;
  assert (expQ.size() > 0)
  else
  begin
    $display("Output appeared with no block outstanding");
    errorCount++;
  end
  if (expQ.size() > 0)
  begin
    e = expQ.pop_front();
    assert (got.cipherText == e.cipherText)
    else
    begin
      $display("ERR outData.cipherText exp %h got %h", e.cipherText, got.cipherText);
      errorCount++;
    end
    assert (got.tag == e.tag)
    else
    begin
      $display("ERR outData.tag exp %h got %h", e.tag, got.tag);
      errorCount++;
    end
  end
endtask

`endif

/* aesEncoderTb.sv */
/*
  Testbench for the pipelined AES-128 encryption engine
  Runs known-answer, streaming, back-pressure, key reload and reset tests against a model
*/
`timescale 1ns/1ps
`default_nettype none

`include "aes_consts.svh"

module aesEncoderTb
  import aesPkg::*;
();

  localparam int clkPeriod      = 10;
  localparam int numBlocks      = 200;
  localparam int pressureBlocks = 100;
  localparam int smallBlocks    = 10;
  localparam int creditProb     = 50;
  localparam int creditCap      = 16;
  localparam int waitLimit      = 400;
  localparam int maxBlockCycles = 40;
  localparam int watchdogMargin = 2000;
  localparam int totalBlocks    = 1 + numBlocks + pressureBlocks + 4 * smallBlocks;

  localparam logic [127:0] katKey    = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam logic [127:0] katPlain  = 128'h3243f6a8885a308d313198a2e0370734;
  localparam logic [127:0] katCipher = 128'h3925841d02dc09fbdc118597196a0b32;

  logic      clock;
  logic      rst;
  logic      keyWrite;
  roundKeyT  keyIn;
  logic      keyReady;
  logic      inValid;
  cipherInT  inData;
  logic      inReady;
  logic      outValid;
  cipherOutT outData;
  logic      outCredit;

  int           errorCount = 0;
  int           testNum = 0;
  int           testsPassed = 0;
  int           testsFailed = 0;
  int           creditsHeld = 0;
  int           creditMode = 0;
  int           creditGap = 0;
  int           outCount = 0;
  bit           sawNotReady = 1'b0;
  logic [127:0] curKey = '0;

  `include "aesRefModel.svh"

  aesEncoderTop dut0 (
    .clock     (clock),
    .rst       (rst),
    .keyWrite  (keyWrite),
    .keyIn     (keyIn),
    .keyReady  (keyReady),
    .inValid   (inValid),
    .inData    (inData),
    .inReady   (inReady),
    .outValid  (outValid),
    .outData   (outData),
    .outCredit (outCredit)
  );

  initial
  begin
    clock = 1'b0;
    forever #(clkPeriod / 2) clock = ~clock;
  end

  initial
  begin
    #(clkPeriod * (totalBlocks * maxBlockCycles + watchdogMargin));
    $display("Watchdog expired before the tests finished");
    $display("=== FAIL ===");
    $finish;
  end

  // Mode 0 withholds credits, 1 grants every cycle, 2 grants at random with stalls
  initial
  begin
    outCredit = 1'b0;
    forever
    begin
      @(posedge clock);
      #1;
      if (creditMode == 2 && creditGap == 0 && $urandom_range(31, 0) == 0)
        creditGap = $urandom_range(70, 30);
      if (creditMode == 2 && creditGap > 0)
      begin
        outCredit = 1'b0;
        creditGap--;
      end
      else if (creditMode == 0 || creditsHeld >= creditCap)
        outCredit = 1'b0;
      else if (creditMode == 1)
        outCredit = 1'b1;
      else
        outCredit = ($urandom_range(99, 0) < creditProb);
    end
  end

  // Everything is sampled mid-cycle and takes effect on the next rising edge
  initial
  begin
    forever
    begin
      @(negedge clock);
      if (rst)
        creditsHeld = 0;
      else
      begin
        if (outValid)
        begin
          assert (creditsHeld > 0)
          else
          begin
            $display("outValid was raised while the DUT held no credit");
            errorCount++;
          end
          checkOutput(outData);
          outCount++;
          if (creditsHeld > 0)
            creditsHeld--;
        end
        if (outCredit)
          creditsHeld++;
        if (inValid && inReady)
          pushExpected(inData, curKey);
        if (keyReady && !inReady)
          sawNotReady = 1'b1;
      end
    end
  end

  task automatic resetDut();
    rst = 1'b1;
    inValid = 1'b0;
    keyWrite = 1'b0;
    expQ.delete();
    repeat (2) @(posedge clock);
    #1;
    rst = 1'b0;
  endtask

  // keyReady must stay low for eleven cycles after the write edge
  task automatic loadKey(input logic [127:0] key);
    keyWrite = 1'b1;
    keyIn = key;
    curKey = key;
    @(posedge clock);
    #1;
    keyWrite = 1'b0;
    for (int k = 0; k <= 11; k++)
    begin
      @(negedge clock);
      assert (keyReady == (k == 11))
      else
      begin
        $display("ERR keyReady exp %h got %h at %0d cycles after keyWrite",
                 (k == 11), keyReady, k);
        errorCount++;
      end
    end
    @(posedge clock);
    #1;
  endtask

  task automatic sendBlock(input cipherInT blk);
    int n;
    n = 0;
    inValid = 1'b1;
    inData = blk;
    @(negedge clock);
    while (!inReady && n < waitLimit)
    begin
      @(negedge clock);
      n++;
    end
    assert (inReady)
    else
    begin
      $display("inReady stayed low for %0d cycles", waitLimit);
      errorCount++;
    end
    @(posedge clock);
    #1;
    inValid = 1'b0;
  endtask

  task automatic sendRandom(input int count);
    cipherInT blk;
    for (int i = 0; i < count; i++)
    begin
      blk.block = {$urandom, $urandom, $urandom, $urandom};
      blk.tag = 8'($urandom);
      sendBlock(blk);
    end
  endtask

  task automatic waitDrained();
    int n;
    n = 0;
    while (expQ.size() > 0 && n < waitLimit)
    begin
      @(negedge clock);
      n++;
    end
    assert (expQ.size() == 0)
    else
    begin
      $display("%0d results still missing after %0d cycles", expQ.size(), waitLimit);
      errorCount++;
    end
    @(posedge clock);
    #1;
  endtask

  task automatic finishTest(input string name, input int errBefore);
    testNum++;
    if (errorCount == errBefore)
    begin
      testsPassed++;
      $display("test %0d %s: ok", testNum, name);
    end
    else
    begin
      testsFailed++;
      $display("test %0d %s: failed with %0d errors", testNum, name, errorCount - errBefore);
    end
  endtask

  initial
  begin
    cipherInT blk;
    int       errBefore;
    int       outBefore;
    void'($urandom(32'h86b7));
    keyIn = '0;
    inData = '0;
    resetDut();

    errBefore = errorCount;
    creditMode = 1;
    assert (encrypt(katKey, katPlain) == katCipher)
    else
    begin
      $display("ERR model ciphertext exp %h got %h", katCipher, encrypt(katKey, katPlain));
      errorCount++;
    end
    loadKey(katKey);
    blk.block = katPlain;
    blk.tag = 8'h5a;
    sendBlock(blk);
    waitDrained();
    assert (lastOut.cipherText == katCipher && lastOut.tag == 8'h5a)
    else
    begin
      $display("ERR outData exp %h got %h", {katCipher, 8'h5a}, lastOut);
      errorCount++;
    end
    finishTest("known answer", errBefore);

    errBefore = errorCount;
    loadKey({$urandom, $urandom, $urandom, $urandom});
    sendRandom(numBlocks);
    waitDrained();
    finishTest("random streaming", errBefore);

    // Open with a long stall so the queue fills and admission stops
    errBefore = errorCount;
    sawNotReady = 1'b0;
    creditGap = 60;
    creditMode = 2;
    sendRandom(pressureBlocks);
    creditMode = 1;
    waitDrained();
    assert (sawNotReady)
    else
    begin
      $display("inReady never fell while credits were withheld");
      errorCount++;
    end
    finishTest("credit back-pressure", errBefore);

    errBefore = errorCount;
    loadKey({$urandom, $urandom, $urandom, $urandom});
    sendRandom(2 * smallBlocks);
    waitDrained();
    finishTest("key reload", errBefore);

    errBefore = errorCount;
    creditMode = 0;
    sendRandom(smallBlocks);
    resetDut();
    @(negedge clock);
    assert (outValid == 1'b0)
    else
    begin
      $display("ERR outValid exp 0 got %h", outValid);
      errorCount++;
    end
    assert (inReady == 1'b0)
    else
    begin
      $display("ERR inReady exp 0 got %h", inReady);
      errorCount++;
    end
    assert (keyReady == 1'b0)
    else
    begin
      $display("ERR keyReady exp 0 got %h", keyReady);
      errorCount++;
    end
    @(posedge clock);
    #1;
    outBefore = outCount;
    loadKey({$urandom, $urandom, $urandom, $urandom});
    sendRandom(smallBlocks);
    repeat (40) @(posedge clock);
    #1;
    assert (outCount == outBefore)
    else
    begin
      $display("Output appeared after reset before any credit was returned");
      errorCount++;
    end
    creditMode = 1;
    waitDrained();
    finishTest("reset state", errBefore);

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             testNum, testsPassed, testsFailed, errorCount);
    if (errorCount == 0 && testsFailed == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
aesPkg.sv
aesKeySchedule.sv
aesRound.sv
aesCipherPipe.sv
aesOutQueue.sv
aesEncoderTop.sv
aesEncoderTb.sv
